/* design/ipod_defines.svh */
`ifndef IPOD_DEFINES_SVH
`define IPOD_DEFINES_SVH

// ====================================================================
// Flash and sample widths
// ====================================================================
`define FLASH_ADDR_W        23
`define FLASH_DATA_W        32
`define SAMPLE_W            16

// Last word address of the stored track
`define TRACK_LAST_WORD     23'h7FFFF

// ====================================================================
// Sample period in CLK_50M cycles
// ====================================================================
`define DIV_W               16
`define SAMPLE_DIV_DEFAULT  2272
`define SAMPLE_DIV_STEP     100
`define SAMPLE_DIV_MIN      272
`define SAMPLE_DIV_MAX      4272

// ====================================================================
// Keyboard command codes, upper case ASCII
// ====================================================================
`define KEY_PLAY            8'h45
`define KEY_PAUSE           8'h44
`define KEY_FWD             8'h46
`define KEY_BWD             8'h42
`define KEY_RESTART         8'h52

`endif

/* design/ipod_pkg.sv */
`include "ipod_defines.svh"

package ipod_pkg;

  // ====================================================================
  // Keyboard input, one-cycle valid with the ASCII code
  // ====================================================================
  typedef struct packed {
    logic       valid;
    logic [7:0] code;
  } kbd_cmd_t;

  // ====================================================================
  // Avalon-style flash read bus
  // ====================================================================
  typedef struct packed {
    logic                     read;
    logic [`FLASH_ADDR_W-1:0] address;
  } flash_req_t;

  typedef struct packed {
    logic                     waitrequest;
    logic                     readdatavalid;
    logic [`FLASH_DATA_W-1:0] readdata;
  } flash_rsp_t;

  // One flash word, seen whole or as two samples
  typedef union packed {
    logic [`FLASH_DATA_W-1:0] raw;
    struct packed {
      logic [`SAMPLE_W-1:0] hi;
      logic [`SAMPLE_W-1:0] lo;
    } half;
  } flash_word_u;

  // Audio sample with its strobe
  typedef struct packed {
    logic                 strobe;
    logic [`SAMPLE_W-1:0] data;
  } audio_out_t;

  typedef enum logic {PAUSED = 1'b0, PLAYING = 1'b1} play_state_t;

endpackage

/* design/rate_timer.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module rate_timer (
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  logic              speed_up,
  input  logic              speed_down,
  input  logic              speed_reset,
  output logic              sample_tick,
  output logic [`DIV_W-1:0] rate_div
);

  localparam logic [`DIV_W-1:0] div_default = `SAMPLE_DIV_DEFAULT;
  localparam logic [`DIV_W-1:0] div_step    = `SAMPLE_DIV_STEP;
  localparam logic [`DIV_W-1:0] div_min     = `SAMPLE_DIV_MIN;
  localparam logic [`DIV_W-1:0] div_max     = `SAMPLE_DIV_MAX;

  logic [`DIV_W-1:0] count;

  // ====================================================================
  // Sample period register
  // ====================================================================
  // Reset strobe wins, then up, then down
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      rate_div <= div_default;
    else if (speed_reset)
      rate_div <= div_default;
    else if (speed_up)
    begin
      if (rate_div < div_min + div_step)
        rate_div <= div_min;
      else
        rate_div <= rate_div - div_step;
    end
    else if (speed_down)
    begin
      if (rate_div > div_max - div_step)
        rate_div <= div_max;
      else
        rate_div <= rate_div + div_step;
    end
  end

  // ====================================================================
  // Down-counter, one tick per period
  // ====================================================================
  // New period is taken only at reload
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      count       <= div_default - 1'b1;
      sample_tick <= 1'b0;
    end
    else if (count == '0)
    begin
      count       <= rate_div - 1'b1;
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count - 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

/* design/player_fsm.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module player_fsm
  import ipod_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  kbd_cmd_t                 key_cmd,
  input  logic                     sample_tick,
  input  logic                     busy,
  output logic                     fetch,
  output logic                     fetch_hi,
  output logic [`FLASH_ADDR_W-1:0] fetch_addr
);

  localparam logic [`FLASH_ADDR_W-1:0] last_word = `TRACK_LAST_WORD;

  // Next sample to fetch
  typedef struct packed {
    logic [`FLASH_ADDR_W-1:0] word;
    logic                     hi;
  } pos_t;

  play_state_t state;
  play_state_t state_nxt;
  logic        fwd;
  logic        fwd_nxt;
  pos_t        pos;
  pos_t        pos_cmd;
  logic        launch;

  // One half-word step with wrap at both track ends
  function automatic pos_t step_pos(input pos_t cur, input logic up);
    pos_t nxt;
    nxt    = cur;
    nxt.hi = ~cur.hi;
    if (up && cur.hi)
      nxt.word = (cur.word == last_word) ? '0 : cur.word + 1'b1;
    else if (!up && !cur.hi)
      nxt.word = (cur.word == '0) ? last_word : cur.word - 1'b1;
    return nxt;
  endfunction

  // ====================================================================
  // Command decode
  // ====================================================================
  // Command applies first, a tick in the same cycle sees its result
  always_comb
  begin
    state_nxt = state;
    fwd_nxt   = fwd;
    pos_cmd   = pos;
    if (key_cmd.valid)
    begin
      case (key_cmd.code)
        `KEY_PLAY:    state_nxt = PLAYING;
        `KEY_PAUSE:   state_nxt = PAUSED;
        `KEY_FWD:
        begin
          fwd_nxt = 1'b1;
          if (!fwd)
            pos_cmd = step_pos(pos, 1'b1);
        end
        `KEY_BWD:
        begin
          fwd_nxt = 1'b0;
          if (fwd)
            pos_cmd = step_pos(pos, 1'b0);
        end
        `KEY_RESTART: pos_cmd = '{word: '0, hi: 1'b0};
        default:      state_nxt = state;
      endcase
    end
    // Ticks while paused or busy are lost
    launch = sample_tick && (state_nxt == PLAYING) && !busy;
  end

  // ====================================================================
  // State, direction and position
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state <= PAUSED;
      fwd   <= 1'b1;
      pos   <= '{word: '0, hi: 1'b0};
      fetch <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      fwd   <= fwd_nxt;
      fetch <= launch;
      if (launch)
        pos <= step_pos(pos_cmd, fwd_nxt);
      else
        pos <= pos_cmd;
    end
  end

  // Held until the next fetch, sample_select reads fetch_hi late
  always_ff @(posedge CLK_50M)
  begin
    if (launch)
    begin
      fetch_addr <= pos_cmd.word;
      fetch_hi   <= pos_cmd.hi;
    end
  end

endmodule

/* design/flash_reader.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module flash_reader
  import ipod_pkg::*;
(
  input  logic                     CLK_50M,
  input  logic                     rst_n,
  input  logic                     fetch,
  input  logic [`FLASH_ADDR_W-1:0] fetch_addr,
  input  flash_rsp_t               flash_rsp,
  output flash_req_t               flash_req,
  output logic                     busy,
  output logic                     word_valid,
  output flash_word_u              word
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} rd_state_t;

  rd_state_t                st;
  logic [`FLASH_ADDR_W-1:0] addr;

  // ====================================================================
  // Read sequencer
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      st         <= ST_IDLE;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (st)
        ST_IDLE:
          if (fetch)
            st <= ST_REQ;
        // Hold read and address while the slave stalls
        ST_REQ:
          if (!flash_rsp.waitrequest)
            st <= ST_WAIT;
        ST_WAIT:
          if (flash_rsp.readdatavalid)
          begin
            st         <= ST_IDLE;
            word_valid <= 1'b1;
          end
        default: st <= ST_IDLE;
      endcase
    end
  end

  // Address and data payload
  always_ff @(posedge CLK_50M)
  begin
    if (fetch && st == ST_IDLE)
      addr <= fetch_addr;
    if (st == ST_WAIT && flash_rsp.readdatavalid)
      word.raw <= flash_rsp.readdata;
  end

  assign flash_req = '{read: (st == ST_REQ), address: addr};
  assign busy      = fetch || (st != ST_IDLE);

endmodule

/* design/sample_select.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module sample_select
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  logic        fetch_hi,
  input  logic        word_valid,
  input  flash_word_u word,
  output audio_out_t  audio
);

  logic                 strobe;
  logic [`SAMPLE_W-1:0] data;

  // ====================================================================
  // Half select and output register
  // ====================================================================
  // Strobe trails word_valid by one cycle
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      strobe <= 1'b0;
    else
      strobe <= word_valid;
  end

  // fetch_hi stays put from fetch to word_valid
  always_ff @(posedge CLK_50M)
  begin
    if (word_valid)
    begin
      if (fetch_hi)
        data <= word.half.hi;
      else
        data <= word.half.lo;
    end
  end

  // Data holds between strobes
  assign audio = '{strobe: strobe, data: data};

endmodule

/* design/ipod_player.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module ipod_player
  import ipod_pkg::*;
(
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  kbd_cmd_t          key_cmd,
  input  logic              speed_up,
  input  logic              speed_down,
  input  logic              speed_reset,
  output flash_req_t        flash_req,
  input  flash_rsp_t        flash_rsp,
  output audio_out_t        audio,
  output logic [`DIV_W-1:0] rate_div
);

  logic                     sample_tick;
  logic                     fetch;
  logic                     fetch_hi;
  logic [`FLASH_ADDR_W-1:0] fetch_addr;
  logic                     busy;
  logic                     word_valid;
  flash_word_u              word;

  // ====================================================================
  // Sample clock
  // ====================================================================
  rate_timer rate_timer_i (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_tick (sample_tick),
    .rate_div    (rate_div)
  );

  // Keyboard control and track position
  player_fsm player_fsm_i (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key_cmd     (key_cmd),
    .sample_tick (sample_tick),
    .busy        (busy),
    .fetch       (fetch),
    .fetch_hi    (fetch_hi),
    .fetch_addr  (fetch_addr)
  );

  // ====================================================================
  // Flash fetch and audio output
  // ====================================================================
  flash_reader flash_reader_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .fetch      (fetch),
    .fetch_addr (fetch_addr),
    .flash_rsp  (flash_rsp),
    .flash_req  (flash_req),
    .busy       (busy),
    .word_valid (word_valid),
    .word       (word)
  );

  sample_select sample_select_i (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .fetch_hi   (fetch_hi),
    .word_valid (word_valid),
    .word       (word),
    .audio      (audio)
  );

endmodule

/* dv/ipod_assert.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module ipod_assert
  import ipod_pkg::*;
(
  input  logic              CLK_50M,
  input  logic              rst_n,
  input  flash_req_t        flash_req,
  input  flash_rsp_t        flash_rsp,
  input  audio_out_t        audio,
  input  logic [`DIV_W-1:0] rate_div
);

  // Number of failed assertions
  int fail_count = 0;

  // ====================================================================
  // Flash bus, audio strobe and period range
  // ====================================================================
  // Stalled request keeps read and address
  read_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
  else
  begin
    fail_count++;
    $error("flash read dropped or address changed under waitrequest");
  end

  strobe_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    audio.strobe |=> !audio.strobe)
  else
  begin
    fail_count++;
    $error("audio strobe longer than one cycle");
  end

  div_in_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    rate_div >= `SAMPLE_DIV_MIN && rate_div <= `SAMPLE_DIV_MAX)
  else
  begin
    fail_count++;
    $error("rate_div outside its limits");
  end

endmodule

/* dv/ipod_tb.sv */
`include "ipod_defines.svh"
`timescale 1ns/1ps

module ipod_tb
  import ipod_pkg::*;
;

  localparam int unsigned half_count   = (`TRACK_LAST_WORD + 1) * 2;
  localparam longint      test_periods = 60;
  localparam longint      watchdog_ns  = test_periods * `SAMPLE_DIV_MAX * 20 * 2;

  logic              CLK_50M;
  logic              rst_n;
  kbd_cmd_t          key_cmd;
  logic              speed_up;
  logic              speed_down;
  logic              speed_reset;
  flash_req_t        flash_req;
  flash_rsp_t        flash_rsp;
  audio_out_t        audio;
  logic [`DIV_W-1:0] rate_div;

  // Reference model
  bit          model_fwd;
  int unsigned model_idx;
  int          model_div;

  logic [31:0] stim_state = 32'ha2d5_6a7a;
  logic [31:0] rsp_state  = ~32'ha2d5_6a7a;
  longint      cycle      = 0;
  longint      rise_cycle[$];
  int          reads_seen   = 0;
  int          samples_seen = 0;
  logic        read_prev    = 1'b0;

  ipod_player dut_i (.*);

  bind ipod_player ipod_assert ipod_assert_i (.*);

  // ====================================================================
  // Helpers
  // ====================================================================
  function automatic logic [31:0] lcg(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // Flash contents depend on every address bit
  function automatic logic [31:0] word_hash(input logic [`FLASH_ADDR_W-1:0] addr);
    return ({9'd0, addr} * 32'h9e37_79b1) ^ {addr[22:7], addr[22:7]};
  endfunction

  // Position as a half-word index with the low half at even values
  function automatic logic [15:0] expected_sample(input int unsigned idx);
    logic [31:0] w;
    w = word_hash(`FLASH_ADDR_W'(idx >> 1));
    return idx[0] ? w[31:16] : w[15:0];
  endfunction

  function automatic int unsigned step_idx(input int unsigned idx, input bit up);
    return up ? (idx + 1) % half_count : (idx + half_count - 1) % half_count;
  endfunction

  function automatic int clamp_div(input int d);
    if (d < `SAMPLE_DIV_MIN)
      return `SAMPLE_DIV_MIN;
    if (d > `SAMPLE_DIV_MAX)
      return `SAMPLE_DIV_MAX;
    return d;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Send one command byte and update the model by the same rules
  task automatic send_key(input logic [7:0] code);
    @(negedge CLK_50M);
    key_cmd = '{valid: 1'b1, code: code};
    case (code)
      `KEY_FWD:
      begin
        if (!model_fwd)
          model_idx = step_idx(model_idx, 1'b1);
        model_fwd = 1'b1;
      end
      `KEY_BWD:
      begin
        if (model_fwd)
          model_idx = step_idx(model_idx, 1'b0);
        model_fwd = 1'b0;
      end
      `KEY_RESTART: model_idx = 0;
      default: ;
    endcase
    @(negedge CLK_50M);
    key_cmd.valid = 1'b0;
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = samples_seen + n;
    wait (samples_seen >= target);
  endtask

  task automatic check_idle(input int periods);
    int reads0;
    int samples0;
    reads0   = reads_seen;
    samples0 = samples_seen;
    repeat (periods * model_div) @(negedge CLK_50M);
    check_value("read rises while paused", reads_seen, reads0);
    check_value("audio strobes while paused", samples_seen, samples0);
  endtask

  // Burst of speed strobes followed by a quiet stretch to measure the period
  task automatic speed_round(input bit faster);
    logic [31:0] r;
    int          pick;
    int          base;
    repeat (16)
    begin
      r    = lcg(stim_state);
      pick = (r >> 16) % 32;
      @(negedge CLK_50M);
      if (pick == 31)
      begin
        speed_reset = 1'b1;
        model_div   = `SAMPLE_DIV_DEFAULT;
      end
      else if ((pick < 28) == faster)
      begin
        speed_up  = 1'b1;
        model_div = clamp_div(model_div - `SAMPLE_DIV_STEP);
      end
      else
      begin
        speed_down = 1'b1;
        model_div  = clamp_div(model_div + `SAMPLE_DIV_STEP);
      end
      @(negedge CLK_50M);
      speed_up    = 1'b0;
      speed_down  = 1'b0;
      speed_reset = 1'b0;
      check_value("rate_div", rate_div, model_div);
      repeat (r[3:0] % 3) @(negedge CLK_50M);
    end
    base = reads_seen;
    wait (reads_seen >= base + 3);
    check_value("read rise spacing", rise_cycle[base + 2] - rise_cycle[base + 1], model_div);
  endtask

  // ====================================================================
  // Clock, flash responder, monitor and watchdog
  // ====================================================================
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
    cycle <= cycle + 1;

  task automatic serve_read();
    logic [31:0]              r;
    logic [`FLASH_ADDR_W-1:0] addr;
    r    = lcg(rsp_state);
    addr = flash_req.address;
    repeat ((r >> 8) % 4) @(negedge CLK_50M);
    flash_rsp.waitrequest = 1'b0;
    @(negedge CLK_50M);
    flash_rsp.waitrequest = 1'b1;
    repeat ((r >> 20) % 4) @(negedge CLK_50M);
    flash_rsp.readdatavalid = 1'b1;
    flash_rsp.readdata      = word_hash(addr);
    @(negedge CLK_50M);
    flash_rsp.readdatavalid = 1'b0;
  endtask

  initial
  begin
    flash_rsp = '{waitrequest: 1'b1, readdatavalid: 1'b0, readdata: '0};
    forever
    begin
      @(negedge CLK_50M);
      if (flash_req.read)
        serve_read();
    end
  end

  always @(negedge CLK_50M)
  begin
    if (rst_n)
    begin
      check_value("assertion failures", dut_i.ipod_assert_i.fail_count, 0);
      if (flash_req.read && !read_prev)
      begin
        rise_cycle.push_back(cycle);
        reads_seen++;
      end
      if (audio.strobe)
      begin
        check_value("audio.data", audio.data, expected_sample(model_idx));
        model_idx = step_idx(model_idx, model_fwd);
        samples_seen++;
      end
    end
    read_prev = flash_req.read;
  end

  initial
  begin
    #(watchdog_ns);
    $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial
  begin
    rst_n       = 1'b0;
    key_cmd     = '0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    model_fwd   = 1'b1;
    model_idx   = 0;
    model_div   = `SAMPLE_DIV_DEFAULT;
    repeat (3) @(negedge CLK_50M);
    rst_n = 1'b1;

    // Paused after reset
    check_value("rate_div", rate_div, model_div);
    check_idle(3);

    // Forward play with an unknown code in between
    send_key(`KEY_PLAY);
    wait_samples(3);
    send_key(8'h41);
    wait_samples(3);

    // Wrap to the last word going backward and turn forward again
    send_key(`KEY_RESTART);
    send_key(`KEY_BWD);
    wait_samples(4);
    send_key(`KEY_FWD);
    wait_samples(4);

    // Pause, resume, restart while backward
    send_key(`KEY_PAUSE);
    check_idle(3);
    send_key(`KEY_PLAY);
    wait_samples(3);
    send_key(`KEY_BWD);
    wait_samples(2);
    send_key(`KEY_RESTART);
    wait_samples(3);

    // Speed changes with clamping at both ends
    send_key(`KEY_FWD);
    repeat (3) speed_round(1'b1);
    repeat (3) speed_round(1'b0);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+design
design/ipod_pkg.sv
design/rate_timer.sv
design/player_fsm.sv
design/flash_reader.sv
design/sample_select.sv
design/ipod_player.sv
dv/ipod_assert.sv
dv/ipod_tb.sv
